/* verilog/img_geom_pkg.sv */
`default_nettype none

package img_geom_pkg;

    // frame geometry in raster order
    localparam int unsigned img_cols = 16;
    localparam int unsigned img_rows = 12;

    localparam int unsigned col_w = $clog2(img_cols);
    localparam int unsigned row_w = $clog2(img_rows);

endpackage

`default_nettype wire

/* verilog/blob_label_pkg.sv */
`default_nettype none

package blob_label_pkg;

    localparam int unsigned label_w    = 6;             // label 0 is background
    localparam int unsigned max_labels = 1 << label_w;  // includes label 0

    localparam int unsigned size_w  = 8;   // 192 pixels per frame
    localparam int unsigned count_w = 6;

    // blob passes when size > max size >> size_shift
    localparam int unsigned size_shift = 3;

endpackage

`default_nettype wire

/* verilog/raster_window.sv */
`timescale 1ns/1ps
`default_nettype none

module raster_window import img_geom_pkg::*, blob_label_pkg::*; #(
    parameter int unsigned cols = img_cols,
    parameter int unsigned rows = img_rows
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_valid,
    input  logic               i_pixel,
    input  logic [label_w-1:0] i_label,
    output logic               o_strobe,
    output logic               o_fg,
    output logic               o_frame_end,
    output logic [label_w-1:0] o_left,
    output logic [label_w-1:0] o_up_left,
    output logic [label_w-1:0] o_up,
    output logic [label_w-1:0] o_up_right
);

    // coordinates of the pixel in the strobe stage
    logic [col_w-1:0]   col_cnt;
    logic [row_w-1:0]   row_cnt;
    logic [label_w-1:0] line_buf [cols];  // [0] newest, [cols-1] is the pixel above
    logic [label_w-1:0] left_r;
    logic [label_w-1:0] up_left_r;
    logic               first_col;
    logic               last_col;
    logic               first_row;
    logic               last_row;

    assign first_col = (col_cnt == '0);
    assign last_col  = (col_cnt == col_w'(cols - 1));
    assign first_row = (row_cnt == '0);
    assign last_row  = (row_cnt == row_w'(rows - 1));

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_strobe    <= 1'b0;
            o_fg        <= 1'b0;
            o_frame_end <= 1'b0;
            col_cnt     <= '0;
            row_cnt     <= '0;
        end else begin
            o_strobe    <= i_valid;
            o_fg        <= i_valid & i_pixel;
            o_frame_end <= o_strobe & last_col & last_row;
            if (o_strobe) begin
                if (last_col) begin
                    col_cnt <= '0;
                    row_cnt <= last_row ? '0 : row_cnt + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_strobe) begin
            line_buf[0] <= i_label;
            for (int k = 1; k < cols; k++) begin
                line_buf[k] <= line_buf[k-1];
            end
            left_r    <= i_label;
            up_left_r <= line_buf[cols-1];  // above becomes above-left
        end
    end

    // outside the image is background
    assign o_left     = first_col ? '0 : left_r;
    assign o_up_left  = (first_col || first_row) ? '0 : up_left_r;
    assign o_up       = first_row ? '0 : line_buf[cols-1];
    assign o_up_right = (last_col || first_row) ? '0 : line_buf[cols-2];

    // no pixels while the tally runs
    a_no_pixel_at_end: assert property (@(posedge i_clk) disable iff (i_rst)
        o_frame_end |-> !i_valid);

endmodule

`default_nettype wire

/* verilog/label_union.sv */
`timescale 1ns/1ps
`default_nettype none

module label_union import blob_label_pkg::*; (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_strobe,
    input  logic               i_fg,
    input  logic [label_w-1:0] i_left,
    input  logic [label_w-1:0] i_up_left,
    input  logic [label_w-1:0] i_up,
    input  logic [label_w-1:0] i_up_right,
    input  logic               i_clear,
    input  logic [label_w-1:0] i_rd_idx,
    output logic [label_w-1:0] o_label,
    output logic [size_w-1:0]  o_rd_size
);

    // parent entries always hold a root, so one lookup resolves a label
    logic [label_w-1:0] parent   [max_labels];
    logic [size_w-1:0]  size_tbl [max_labels];
    logic [label_w-1:0] next_lbl;  // last label handed out
    logic [label_w-1:0] new_lbl;
    logic [label_w-1:0] root_l;
    logic [label_w-1:0] root_ul;
    logic [label_w-1:0] root_u;
    logic [label_w-1:0] root_ur;
    logic [label_w-1:0] win;
    logic [label_w-1:0] lose;
    logic               pix_fg;
    logic               new_req;
    logic               merge;

    // smaller of two labels, ignoring background
    function automatic logic [label_w-1:0] min_nz(
        input logic [label_w-1:0] a,
        input logic [label_w-1:0] b
    );
        if (a == '0) begin
            return b;
        end
        if (b == '0) begin
            return a;
        end
        return (a < b) ? a : b;
    endfunction

    function automatic logic [label_w-1:0] max2(
        input logic [label_w-1:0] a,
        input logic [label_w-1:0] b
    );
        return (a > b) ? a : b;
    endfunction

    assign root_l  = parent[i_left];
    assign root_ul = parent[i_up_left];
    assign root_u  = parent[i_up];
    assign root_ur = parent[i_up_right];

    // at most two distinct roots can meet at one pixel
    assign win  = min_nz(min_nz(root_l, root_ul), min_nz(root_u, root_ur));
    assign lose = max2(max2(root_l, root_ul), max2(root_u, root_ur));

    assign pix_fg  = i_strobe & i_fg;
    assign new_req = pix_fg & (win == '0);
    assign merge   = pix_fg & (lose != win);
    assign new_lbl = next_lbl + 1'b1;

    assign o_label   = i_fg ? ((win == '0) ? new_lbl : win) : '0;
    assign o_rd_size = size_tbl[i_rd_idx];

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            next_lbl <= '0;
            for (int i = 0; i < max_labels; i++) begin
                parent[i]   <= '0;
                size_tbl[i] <= '0;
            end
        end else if (i_clear) begin
            next_lbl <= '0;
            for (int i = 0; i < max_labels; i++) begin
                parent[i]   <= '0;
                size_tbl[i] <= '0;
            end
        end else if (new_req) begin
            parent[new_lbl]   <= new_lbl;
            size_tbl[new_lbl] <= size_w'(1);
            next_lbl          <= new_lbl;
        end else if (pix_fg) begin
            if (merge) begin
                // relink the whole losing set in one cycle
                for (int i = 0; i < max_labels; i++) begin
                    if (parent[i] == lose) begin
                        parent[i] <= win;
                    end
                end
                size_tbl[win]  <= size_tbl[win] + size_tbl[lose] + 1'b1;
                size_tbl[lose] <= '0;
            end else begin
                size_tbl[win] <= size_tbl[win] + 1'b1;
            end
        end
    end

    a_label_room: assert property (@(posedge i_clk) disable iff (i_rst)
        new_req |-> (next_lbl != label_w'(max_labels - 1)));

    // roots only ever move to smaller labels
    for (genvar g = 0; g < max_labels; g++) begin : g_parent_chk
        a_parent_order: assert property (@(posedge i_clk) disable iff (i_rst)
            parent[g] <= label_w'(g));
    end

endmodule

`default_nettype wire

/* verilog/blob_tally.sv */
`timescale 1ns/1ps
`default_nettype none

module blob_tally import blob_label_pkg::*; (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_frame_end,
    input  logic [size_w-1:0]  i_rd_size,
    output logic [label_w-1:0] o_rd_idx,
    output logic               o_valid,
    output logic [count_w-1:0] o_count
);

    typedef enum logic [1:0] {
        st_idle,
        st_max,
        st_count
    } state_t;

    state_t             state;
    logic [label_w-1:0] idx;
    logic [size_w-1:0]  max_size;
    logic [count_w-1:0] cnt;
    logic               last_idx;
    logic               big;

    assign o_rd_idx = idx;
    assign last_idx = (idx == label_w'(max_labels - 1));
    assign big      = i_rd_size > (max_size >> size_shift);  // empty entries never pass

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state    <= st_idle;
            idx      <= '0;
            max_size <= '0;
            cnt      <= '0;
            o_valid  <= 1'b0;
            o_count  <= '0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                st_idle: begin
                    idx      <= '0;
                    max_size <= '0;
                    cnt      <= '0;
                    if (i_frame_end) begin
                        state <= st_max;
                    end
                end
                st_max: begin
                    if (i_rd_size > max_size) begin
                        max_size <= i_rd_size;
                    end
                    idx <= idx + 1'b1;  // wraps to 0 for the count pass
                    if (last_idx) begin
                        state <= st_count;
                    end
                end
                st_count: begin
                    idx <= idx + 1'b1;
                    if (big) begin
                        cnt <= cnt + 1'b1;
                    end
                    if (last_idx) begin
                        o_count <= cnt + count_w'(big);
                        o_valid <= 1'b1;
                        state   <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // a new frame may only end once the previous tally is out
    a_end_when_idle: assert property (@(posedge i_clk) disable iff (i_rst)
        i_frame_end |-> (state == st_idle));

endmodule

`default_nettype wire

/* verilog/blob_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module blob_counter import img_geom_pkg::*, blob_label_pkg::*; (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_valid,
    input  logic               i_pixel,
    output logic               o_valid,
    output logic [count_w-1:0] o_count
);

    logic               strobe;
    logic               fg;
    logic               frame_end;
    logic [label_w-1:0] nb_left;
    logic [label_w-1:0] nb_up_left;
    logic [label_w-1:0] nb_up;
    logic [label_w-1:0] nb_up_right;
    logic [label_w-1:0] label;
    logic [label_w-1:0] rd_idx;
    logic [size_w-1:0]  rd_size;

    raster_window #(
        .cols (img_cols),
        .rows (img_rows)
    ) u_window (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_valid     (i_valid),
        .i_pixel     (i_pixel),
        .i_label     (label),
        .o_strobe    (strobe),
        .o_fg        (fg),
        .o_frame_end (frame_end),
        .o_left      (nb_left),
        .o_up_left   (nb_up_left),
        .o_up        (nb_up),
        .o_up_right  (nb_up_right)
    );

    // result pulse empties the tables for the next frame
    label_union u_union (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_strobe   (strobe),
        .i_fg       (fg),
        .i_left     (nb_left),
        .i_up_left  (nb_up_left),
        .i_up       (nb_up),
        .i_up_right (nb_up_right),
        .i_clear    (o_valid),
        .i_rd_idx   (rd_idx),
        .o_label    (label),
        .o_rd_size  (rd_size)
    );

    blob_tally u_tally (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_frame_end (frame_end),
        .i_rd_size   (rd_size),
        .o_rd_idx    (rd_idx),
        .o_valid     (o_valid),
        .o_count     (o_count)
    );

endmodule

`default_nettype wire

/* verif/tb_blob_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_blob_counter import img_geom_pkg::*, blob_label_pkg::*; ();

    localparam int n_frames    = 3;
    localparam int words_per   = img_rows + 1;  // header word, then the rows
    localparam int cycle_limit = n_frames * (img_cols * img_rows * 4 + 2 * max_labels + 20);

    logic               i_clk;
    logic               i_rst;
    logic               i_valid;
    logic               i_pixel;
    logic               o_valid;
    logic [count_w-1:0] o_count;

    logic [img_cols-1:0] stim_mem [n_frames * words_per];
    logic [31:0]         lcg_state;
    logic [count_w-1:0]  held_count = '0;
    int                  errors = 0;
    int                  checks = 0;
    int                  pulses = 0;
    int                  cycles = 0;

    blob_counter DUT (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (i_valid),
        .i_pixel (i_pixel),
        .o_valid (o_valid),
        .o_count (o_count)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // one pixel, then 0 to 3 idle cycles
    task automatic drive_pixel(input logic pix);
        int gap;
        lcg_state = lcg_next(lcg_state);
        gap = int'(lcg_state[17:16]);
        @(posedge i_clk);
        i_valid <= 1'b1;
        i_pixel <= pix;
        repeat (gap) begin
            @(posedge i_clk);
            i_valid <= 1'b0;
            i_pixel <= 1'b0;
        end
    endtask

    task automatic run_frame(input int f);
        logic [img_cols-1:0] row;
        logic [count_w-1:0]  expected;
        expected = count_w'(stim_mem[f * words_per]);
        for (int r = 0; r < img_rows; r++) begin
            row = stim_mem[f * words_per + 1 + r];
            for (int c = 0; c < img_cols; c++) begin
                drive_pixel(row[img_cols - 1 - c]);  // column 0 is the msb
            end
        end
        @(posedge i_clk);
        i_valid <= 1'b0;
        i_pixel <= 1'b0;
        do begin
            @(posedge i_clk);
        end while (o_valid !== 1'b1);
        checks++;
        assert (o_count == expected) else begin
            errors++;
            $display("CHECK FAILED: frame %0d o_count = 0x%0h, expected 0x%0h",
                     f, o_count, expected);
        end
        @(posedge i_clk);  // monitor has counted the pulse by now
        checks++;
        assert (pulses == f + 1) else begin
            errors++;
            $display("CHECK FAILED: o_valid pulses = 0x%0h, expected 0x%0h", pulses, f + 1);
        end
    endtask

    // o_count may only change together with o_valid
    always @(posedge i_clk) begin
        if (!i_rst) begin
            if (o_valid) begin
                pulses++;
                held_count = o_count;
            end else begin
                assert (o_count == held_count) else begin
                    errors++;
                    $display("CHECK FAILED: o_count = 0x%0h between pulses, held 0x%0h",
                             o_count, held_count);
                end
            end
        end
    end

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge i_clk);
            if (!i_rst) begin
                cycles++;
            end
        end
        $display("timeout: no end of test after %0d cycles", cycles);
        $display("errors: %0d, checks: %0d", errors, checks);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        i_rst     = 1'b1;
        i_valid   = 1'b0;
        i_pixel   = 1'b0;
        lcg_state = 32'd77732;
        $readmemh("verif/blob_stimulus.txt", stim_mem);
        repeat (16) @(posedge i_clk);
        i_rst <= 1'b0;
        assert (!$isunknown(stim_mem[n_frames * words_per - 1])) else begin
            errors++;
            $display("stimulus file is missing or shorter than expected");
        end
        if (errors == 0) begin
            for (int f = 0; f < n_frames; f++) begin
                run_frame(f);
            end
            repeat (8) @(posedge i_clk);
            checks++;
            assert (pulses == n_frames) else begin
                errors++;
                $display("CHECK FAILED: o_valid pulses = 0x%0h, expected 0x%0h",
                         pulses, n_frames);
            end
        end
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
verilog/img_geom_pkg.sv
verilog/blob_label_pkg.sv
verilog/raster_window.sv
verilog/label_union.sv
verilog/blob_tally.sv
verilog/blob_counter.sv
verif/tb_blob_counter.sv

/* Makefile */
SIM      ?= verilator
SIMFLAGS ?= --binary --timing --assert --timescale 1ns/1ps
TOP      := tb_blob_counter
FILELIST := project.f
OBJDIR   := obj_dir
LOG      := sim.log
PASS_MSG := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "log check: ok"; \
	else \
		echo "log check: pass line not found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* verif/blob_stimulus.txt */
// per frame: one word with the expected blob count, then twelve rows,
// each row 16 bits with column 0 in the most significant bit
// frame 0: 4x4 square plus two single pixels
0001
0000
0000
1E00
1E00
1E00
1E00
0000
0000
0020
0000
4000
0000
// frame 1: U shape joined at the bottom, plus a bar of three
0002
0000
2200
2200
2200
2200
2200
2200
3E00
0000
0000
0038
0000
// frame 2: first row and last column, diagonal chains, bars split by one column
0006
000F
8001
8001
8000
2088
1050
0820
1000
200A
000A
000A
000A
